// File: flist.f
rtl/oflow_mem_pkg.sv
rtl/oflow_mem_port_if.sv
rtl/oflow_history_pointers.sv
rtl/oflow_dual_port_ram.sv
rtl/oflow_mem_buffer.sv
rtl/oflow_access_ctrl.sv
rtl/oflow_mem_top.sv
tests/oflow_mem_checker.sv
tests/oflow_mem_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the history memory testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module oflow_mem_tb \
	-f flist.f -o oflow_mem_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "verilator build failed, see build.log"
	exit 1
fi

./obj_dir/oflow_mem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi
grep -q "Simulation completed successfully" sim.log

// File: tests/oflow_mem_tb.sv
// testbench for the optical-flow history memory
// walks a table of frame / offset transactions through the four-phase
// handshake, keeps a flat model of the RAM and hands expected data to the checker
`default_nettype none

module oflow_mem_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import oflow_mem_pkg::*;

	typedef struct packed {
		logic [FRAME_NUM_WIDTH-1:0] frame;
		logic [HIST_WIDTH-1:0]      n;    // history count N
		logic                       wr, en0, en1;
		logic [OFFSET_WIDTH-1:0]    off0, off1;
		logic [1:0]                 hold; // extra cycles with req held high
	} row_t;

	logic                       clk = 1'b0;
	logic                       reset_N = 1'b0;
	logic [FRAME_NUM_WIDTH-1:0] frame_num = '0;
	logic [HIST_WIDTH-1:0]      num_of_history_frames = HIST_WIDTH'(1);
	logic                       req = 1'b0, we = 1'b0, en_0 = 1'b0, en_1 = 1'b0;
	logic [OFFSET_WIDTH-1:0]    offset_0 = '0, offset_1 = '0;
	logic [DATA_WIDTH-1:0]      data_in_0 = '0, data_in_1 = '0;
	logic                       ack;
	logic [DATA_WIDTH-1:0]      data_out_0, data_out_1;
	logic                       check_stb = 1'b0, exp_ack = 1'b0, done = 1'b0;
	logic [DATA_WIDTH-1:0]      exp_0 = '0, exp_1 = '0; // zero out of reset
	int                         test_count, error_count;

	row_t                  rows [$];
	logic [DATA_WIDTH-1:0] model [MEM_DEPTH]; // flat copy of the RAM
	integer                seed = 32'h2cc6;
	int                    cycles = 0;
	int                    limit = 0;

	oflow_mem_top dut0 (.*);
	oflow_mem_checker checker0 (.*);

	initial forever #2 clk = ~clk; // 4 ns period

	always @(posedge clk) begin
		cycles++;
		if (cycles > limit) begin
			$display("timeout, the run did not finish within %0d cycles", limit);
			$display("Simulation failed");
			$finish;
		end
	end

	task automatic add_row(input int frame, n, wr, en0, en1, off0, off1, hold);
		rows.push_back('{FRAME_NUM_WIDTH'(frame), HIST_WIDTH'(n), 1'(wr), 1'(en0), 1'(en1),
			OFFSET_WIDTH'(off0), OFFSET_WIDTH'(off1), 2'(hold)});
	endtask

	// base = (frame mod N) * floor(depth / N), plus the port offset
	function automatic logic [ADDR_WIDTH-1:0] region_addr(input row_t r, input int off);
		int slot;
		slot = int'(r.frame) % int'(r.n);
		return ADDR_WIDTH'(slot * (MEM_DEPTH / int'(r.n)) + off);
	endfunction

	task automatic wait_ack(input logic level);
		do begin
			@(posedge clk);
			#1;
		end while (ack !== level);
	endtask

	// ----------------------------------------------------------------------
	// one table row through the four-phase handshake
	// ----------------------------------------------------------------------
	task automatic run_row(input row_t r);
		logic [ADDR_WIDTH-1:0] a0;
		logic [ADDR_WIDTH-1:0] a1;
		a0 = region_addr(r, int'(r.off0));
		a1 = region_addr(r, int'(r.off1));
		frame_num = r.frame; // req and ack both low here
		num_of_history_frames = r.n;
		@(posedge clk);
		#1; // new base is in place
		we       = r.wr;
		en_0     = r.en0;
		en_1     = r.en1;
		offset_0 = r.off0;
		offset_1 = r.off1;
		if (r.wr) begin
			data_in_0 = $random(seed);
			data_in_1 = $random(seed);
		end
		req = 1'b1;
		wait_ack(1'b1);
		if (r.wr) begin
			if (r.en0)
				model[a0] = data_in_0;
			if (r.en1)
				model[a1] = data_in_1; // port 1 last, wins a shared address
		end else begin
			if (r.en0)
				exp_0 = model[a0];
			if (r.en1)
				exp_1 = model[a1];
		end
		@(posedge clk); // req still high, ack has to hold
		#1;
		exp_ack   = 1'b1;
		check_stb = 1'b1;
		@(posedge clk);
		#1;
		check_stb = 1'b0;
		repeat (r.hold) begin
			@(posedge clk);
			#1;
		end
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	initial begin
		//      frm  N  wr e0 e1 off0 off1 hold
		add_row(0, 1, 1, 1, 1,  3, 40, 0);
		add_row(0, 1, 0, 1, 1,  3, 40, 2); // back-pressure
		add_row(0, 2, 1, 1, 1,  0,  5, 0);
		add_row(1, 2, 1, 1, 1,  0,  5, 0); // addresses 64 and 69
		add_row(1, 2, 0, 1, 1,  5,  0, 1);
		add_row(2, 2, 0, 1, 1,  0,  5, 0); // back in region 0
		add_row(0, 3, 1, 1, 1,  2, 41, 0);
		add_row(1, 3, 1, 1, 1,  2, 41, 0);
		add_row(2, 3, 1, 1, 1,  2, 41, 0);
		add_row(3, 3, 0, 1, 1,  2, 41, 3); // frame 3 sees frame 0 data
		add_row(0, 4, 1, 1, 1,  9,  9, 0); // same address, port 1 wins
		add_row(0, 4, 0, 1, 1,  9,  9, 0);
		add_row(1, 4, 1, 1, 0,  0,  1, 0); // port 1 idle on the write
		add_row(1, 4, 0, 0, 1,  5,  0, 0); // port 0 keeps its data
		add_row(2, 4, 0, 1, 0,  0,  7, 2); // address 64, written under N = 2
		add_row(3, 4, 1, 1, 1,  4, 31, 0); // last region, 100 and 127
		add_row(3, 4, 0, 1, 1, 31,  4, 0);
		add_row(0, 5, 1, 1, 1, 24,  0, 0);
		add_row(1, 5, 1, 1, 1, 10, 24, 0);
		add_row(2, 5, 1, 1, 1, 10,  0, 0);
		add_row(3, 5, 1, 0, 1,  0, 10, 0);
		add_row(4, 5, 1, 1, 1, 10, 11, 0);
		add_row(5, 5, 0, 1, 1, 24,  0, 1); // wraps to slot 0
		add_row(6, 5, 0, 1, 1, 10, 24, 0);
		limit = rows.size() * 12 + 100; // a row takes at most about 11 cycles
		repeat (5) @(posedge clk);
		#1;
		reset_N   = 1'b1;
		check_stb = 1'b1; // reset state first
		@(posedge clk);
		#1;
		check_stb = 1'b0;
		foreach (rows[i])
			run_row(rows[i]);
		done = 1'b1;
		@(posedge clk);
		#1;
		done = 1'b0;
		if (test_count != rows.size() + 1)
			$display("only %0d of %0d tests were checked", test_count, rows.size() + 1);
		if (error_count == 0 && test_count == rows.size() + 1)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/oflow_mem_checker.sv
// result checker for the history memory
// watches the top-level handshake, compares ack and data_out with the
// expected values from the testbench, counts tests and errors
`default_nettype none

module oflow_mem_checker (
	input  logic                                 clk, reset_N,
	input  logic                                 req, ack,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0] data_out_0, data_out_1,
	input  logic                                 check_stb, exp_ack, // compare this cycle
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0] exp_0, exp_1,
	input  logic                                 done, // print totals
	output int                                   test_count, error_count
);
	timeunit 1ns;
	timeprecision 100ps;
	import oflow_mem_pkg::*;

	logic                  armed = 1'b0; // req sampled, ack not up yet
	int                    edges = 0;    // edges seen since then
	int                    tests = 0;
	int                    errors = 0;
	int                    test_errs = 0; // inside the current test
	logic                  prev_req = 1'b0, prev_ack = 1'b0;
	logic [DATA_WIDTH-1:0] prev_0, prev_1;

	assign test_count  = tests;
	assign error_count = errors;

	task automatic report_failure(input string msg);
		$display("at %0d ns %s", $time, msg);
		errors++;
		test_errs++;
	endtask

	task automatic compare_value(input string name, input logic [DATA_WIDTH-1:0] expected,
		input logic [DATA_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("ERR at %0d ns %s expected %h got %h", $time, name, expected, actual);
			errors++;
			test_errs++;
		end
	endtask

	// ----------------------------------------------------------------------
	// sampled mid-cycle, away from the driving edges
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (!reset_N) begin
			armed    = 1'b0;
			prev_ack = 1'b0;
		end else begin
			if (!armed && req && !ack) begin
				armed = 1'b1; // E0 is the next edge
				edges = 0;
			end else if (armed && !ack) begin
				edges++;
			end else if (armed) begin
				armed = 1'b0;
				if (edges != 3)
					report_failure($sformatf("ack rose %0d edges after req, not 3", edges));
			end
			if (prev_ack && prev_req && !ack)
				report_failure("ack fell while req was still high");
			if (prev_ack && !prev_req && ack)
				report_failure("ack stayed high after req dropped");
			if (prev_ack && ack && {data_out_0, data_out_1} !== {prev_0, prev_1})
				report_failure("data_out changed while ack was high");
			if (check_stb) begin
				compare_value("ack", DATA_WIDTH'(exp_ack), DATA_WIDTH'(ack));
				compare_value("data_out_0", exp_0, data_out_0);
				compare_value("data_out_1", exp_1, data_out_1);
				tests++;
				if (test_errs == 0)
					$display("test %0d passed", tests);
				else
					$display("test %0d failed with %0d errors", tests, test_errs);
				test_errs = 0;
			end
			if (done)
				$display("%0d tests checked, %0d errors", tests, errors);
			prev_req = req;
			prev_ack = ack;
			prev_0   = data_out_0;
			prev_1   = data_out_1;
		end
	end

endmodule

`default_nettype wire

// File: rtl/oflow_mem_top.sv
// optical-flow history memory, top level
// handshake controller in front of the region-split feature memory
`default_nettype none

module oflow_mem_top (
	input  logic                                      clk,
	input  logic                                      reset_N,
	input  logic [oflow_mem_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_mem_pkg::HIST_WIDTH-1:0]      num_of_history_frames,
	input  logic                                      req,
	output logic                                      ack,
	input  logic                                      we,
	input  logic                                      en_0,
	input  logic                                      en_1,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH-1:0]    offset_0,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH-1:0]    offset_1,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_in_0,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_in_1,
	output logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_out_0,
	output logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_out_1
);
	import oflow_mem_pkg::*;

	logic                  csb_0;  // controller strobes
	logic                  csb_1;
	logic                  mem_we;
	logic                  mem_oeb;
	logic [DATA_WIDTH-1:0] rdata_0; // raw RAM data back to the controller
	logic [DATA_WIDTH-1:0] rdata_1;

	oflow_access_ctrl u_ctrl (
		.clk        (clk),
		.reset_N    (reset_N),
		.req        (req),
		.we_req     (we),
		.en_0       (en_0),
		.en_1       (en_1),
		.ack        (ack),
		.csb_0      (csb_0),
		.csb_1      (csb_1),
		.we         (mem_we),
		.oeb        (mem_oeb),
		.rdata_0    (rdata_0),
		.rdata_1    (rdata_1),
		.data_out_0 (data_out_0),
		.data_out_1 (data_out_1)
	);

	oflow_mem_buffer u_buffer (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.offset_0              (offset_0),
		.offset_1              (offset_1),
		.data_in_0             (data_in_0),
		.data_in_1             (data_in_1),
		.csb_0                 (csb_0),
		.csb_1                 (csb_1),
		.we                    (mem_we),
		.oeb                   (mem_oeb),
		.data_out_0            (rdata_0),
		.data_out_1            (rdata_1)
	);

endmodule

`default_nettype wire

// File: rtl/oflow_access_ctrl.sv
// memory access controller
// serves the four-phase req/ack handshake; each request becomes exactly
// one memory cycle, read data is held on data_out until the next read
`default_nettype none

module oflow_access_ctrl (
	input  logic                                 clk,
	input  logic                                 reset_N,
	input  logic                                 req,
	input  logic                                 we_req, // high = write
	input  logic                                 en_0,
	input  logic                                 en_1,
	output logic                                 ack,
	output logic                                 csb_0,
	output logic                                 csb_1,
	output logic                                 we,
	output logic                                 oeb,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0] rdata_0,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0] rdata_1,
	output logic [oflow_mem_pkg::DATA_WIDTH-1:0] data_out_0,
	output logic [oflow_mem_pkg::DATA_WIDTH-1:0] data_out_1
);

	typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_CAPTURE, ST_ACK} state_t;

	state_t state;
	logic   capture; // first cycle in ack state, RAM data valid

	assign capture = (state == ST_ACK) && !ack;

	// --------------------------------------------------------------------
	// handshake FSM, strobes registered one state behind
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			state <= ST_IDLE;
			ack   <= 1'b0;
			csb_0 <= 1'b1;
			csb_1 <= 1'b1;
			we    <= 1'b0;
			oeb   <= 1'b1;
		end else begin
			csb_0 <= !(state == ST_ACCESS && en_0); // one select cycle
			csb_1 <= !(state == ST_ACCESS && en_1);
			we    <= (state == ST_ACCESS) && we_req;
			// read data has to be enabled up to the capture edge
			oeb   <= !((state == ST_ACCESS || state == ST_CAPTURE) && !we_req);
			case (state)
				ST_IDLE:    if (req && !ack) state <= ST_ACCESS;
				ST_ACCESS:  state <= ST_CAPTURE; // strobes go out
				ST_CAPTURE: state <= ST_ACK;     // RAM register loads
				ST_ACK: begin
					if (!ack) begin
						ack <= 1'b1;
					end else if (!req) begin
						ack   <= 1'b0; // requester released
						state <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read data, only enabled ports of a read
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			data_out_0 <= '0;
			data_out_1 <= '0;
		end else if (capture && !we_req) begin
			if (en_0)
				data_out_0 <= rdata_0;
			if (en_1)
				data_out_1 <= rdata_1;
		end
	end

	ack_needs_req: assert property (@(posedge clk) disable iff (!reset_N)
		$rose(ack) |-> req);

	// selects idle, then low for one cycle per enabled port, then idle again
	one_select: assert property (@(posedge clk) disable iff (!reset_N)
		(state == ST_IDLE && req && !ack) |=> (csb_0 && csb_1)
			##1 (csb_0 == !en_0 && csb_1 == !en_1) ##1 (csb_0 && csb_1));

endmodule

`default_nettype wire

// File: rtl/oflow_mem_buffer.sv
// history-frame memory buffer
// splits the feature RAM into N regions, one per past frame; each port
// address is the current region base plus that port's offset
`default_nettype none

module oflow_mem_buffer (
	input  logic                                      clk,
	input  logic                                      reset_N,
	input  logic [oflow_mem_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_mem_pkg::HIST_WIDTH-1:0]      num_of_history_frames,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH-1:0]    offset_0,
	input  logic [oflow_mem_pkg::OFFSET_WIDTH-1:0]    offset_1,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_in_0,
	input  logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_in_1,
	input  logic                                      csb_0,
	input  logic                                      csb_1,
	input  logic                                      we,  // high = write
	input  logic                                      oeb,
	output logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_out_0,
	output logic [oflow_mem_pkg::DATA_WIDTH-1:0]      data_out_1
);
	import oflow_mem_pkg::*;

	logic [ADDR_WIDTH-1:0] base_addr; // start of the current region
	logic [ADDR_WIDTH:0]   size;

	oflow_mem_port_if mem_port_0 ();
	oflow_mem_port_if mem_port_1 ();

	// --------------------------------------------------------------------
	// region base
	// --------------------------------------------------------------------
	oflow_history_pointers u_pointers (
		.clk                   (clk),
		.reset_N               (reset_N),
		.frame_num             (frame_num),
		.num_of_history_frames (num_of_history_frames),
		.base_addr             (base_addr)
	);

	// --------------------------------------------------------------------
	// port 0 / port 1 routing
	// --------------------------------------------------------------------
	assign mem_port_0.addr  = base_addr + ADDR_WIDTH'(offset_0);
	assign mem_port_0.wdata = data_in_0;
	assign mem_port_0.csb   = csb_0;
	assign mem_port_0.web   = ~we; // RAM wants write low
	assign mem_port_0.oeb   = oeb;

	assign mem_port_1.addr  = base_addr + ADDR_WIDTH'(offset_1);
	assign mem_port_1.wdata = data_in_1;
	assign mem_port_1.csb   = csb_1;
	assign mem_port_1.web   = ~we;
	assign mem_port_1.oeb   = oeb;

	assign data_out_0 = mem_port_0.rdata;
	assign data_out_1 = mem_port_1.rdata;

	oflow_dual_port_ram u_ram (
		.clk     (clk),
		.reset_N (reset_N),
		.port_0  (mem_port_0.ram_side),
		.port_1  (mem_port_1.ram_side)
	);

	// a selected port must stay inside its region, else it hits the next frame
	assign size = region_size(num_of_history_frames);

	offset_in_region: assert property (@(posedge clk) disable iff (!reset_N)
		(csb_0 || offset_0 < size) && (csb_1 || offset_1 < size));

endmodule

`default_nettype wire

// File: rtl/oflow_dual_port_ram.sv
// two-port synchronous feature RAM
// writes on select with web low, reads into an output register on select
// with web high; read data is forced to zero while oeb is high
`default_nettype none

module oflow_dual_port_ram (
	input logic                clk,
	input logic                reset_N,
	oflow_mem_port_if.ram_side port_0,
	oflow_mem_port_if.ram_side port_1
);
	import oflow_mem_pkg::*;

	logic [DATA_WIDTH-1:0] mem [MEM_DEPTH]; // storage, no reset
	logic [DATA_WIDTH-1:0] rd_q_0;
	logic [DATA_WIDTH-1:0] rd_q_1;

	// --------------------------------------------------------------------
	// write side
	// --------------------------------------------------------------------
	// port 1 is assigned last, it wins on a shared address
	always_ff @(posedge clk) begin
		if (!port_0.csb && !port_0.web)
			mem[port_0.addr] <= port_0.wdata;
		if (!port_1.csb && !port_1.web)
			mem[port_1.addr] <= port_1.wdata;
	end

	// --------------------------------------------------------------------
	// read side
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			rd_q_0 <= '0;
			rd_q_1 <= '0;
		end else begin
			if (!port_0.csb && port_0.web)
				rd_q_0 <= mem[port_0.addr]; // old data on same-cycle write
			if (!port_1.csb && port_1.web)
				rd_q_1 <= mem[port_1.addr];
		end
	end

	// output enable gates the registered data
	assign port_0.rdata = port_0.oeb ? '0 : rd_q_0;
	assign port_1.rdata = port_1.oeb ? '0 : rd_q_1;

endmodule

`default_nettype wire

// File: rtl/oflow_history_pointers.sv
// history pointer table
// holds one base address per history region and the slot of the current
// frame; the table is loaded at frame 0, the slot steps on every new frame
`default_nettype none

module oflow_history_pointers (
	input  logic                                      clk,
	input  logic                                      reset_N,
	input  logic [oflow_mem_pkg::FRAME_NUM_WIDTH-1:0] frame_num,
	input  logic [oflow_mem_pkg::HIST_WIDTH-1:0]      num_of_history_frames,
	output logic [oflow_mem_pkg::ADDR_WIDTH-1:0]      base_addr
);
	import oflow_mem_pkg::*;

	logic [ADDR_WIDTH-1:0]      bases [MAX_HISTORY]; // region start addresses
	logic [HIST_WIDTH-1:0]      slot;                // frame_num mod N
	logic [FRAME_NUM_WIDTH-1:0] frame_prev;          // last seen frame
	logic [ADDR_WIDTH:0]        size;
	logic [HIST_WIDTH-1:0]      last_slot;

	assign size      = region_size(num_of_history_frames);
	assign last_slot = num_of_history_frames - HIST_WIDTH'(1);

	// --------------------------------------------------------------------
	// region table
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			for (int k = 0; k < MAX_HISTORY; k++) begin
				bases[k] <= '0;
			end
		end else if (frame_num == '0) begin
			// base k = k * size, only regions below N are live
			for (int k = 0; k < MAX_HISTORY; k++) begin
				if (k < int'(num_of_history_frames))
					bases[k] <= ADDR_WIDTH'(k * size);
				else
					bases[k] <= '0;
			end
		end
	end

	// --------------------------------------------------------------------
	// slot counter, replaces the modulo
	// --------------------------------------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_N) begin
			slot       <= '0;
			frame_prev <= '0;
		end else begin
			frame_prev <= frame_num;
			if (frame_num == '0) begin
				slot <= '0; // restart of the sequence
			end else if (frame_num != frame_prev) begin
				if (slot >= last_slot)
					slot <= '0; // wrap N-1 -> 0
				else
					slot <= slot + 1'b1;
			end
		end
	end

	assign base_addr = bases[slot]; // slot never reaches N

	// N must be legal whenever the table loads
	hist_in_range: assert property (@(posedge clk) disable iff (!reset_N)
		frame_num == '0 |-> num_of_history_frames inside {[1:MAX_HISTORY]});

	// counter tracks frame_num mod N only if frames advance one at a time
	frame_steps: assert property (@(posedge clk) disable iff (!reset_N)
		frame_num != frame_prev |->
			frame_num == '0 || frame_num == FRAME_NUM_WIDTH'(frame_prev + 1'b1));

endmodule

`default_nettype wire

// File: rtl/oflow_mem_port_if.sv
// one port of the feature RAM
// address, write data and active-low strobes toward the RAM, read data back
`default_nettype none

interface oflow_mem_port_if;
	import oflow_mem_pkg::*;

	logic [ADDR_WIDTH-1:0] addr;
	logic [DATA_WIDTH-1:0] wdata;
	logic                  csb;   // chip select, low active
	logic                  web;   // low = write, high = read
	logic                  oeb;   // output enable, low active
	logic [DATA_WIDTH-1:0] rdata; // from the RAM

	// buffer drives the request
	modport buf_side (
		output addr, wdata, csb, web, oeb,
		input  rdata
	);

	// RAM answers it
	modport ram_side (
		input  addr, wdata, csb, web, oeb,
		output rdata
	);

endinterface

`default_nettype wire

// File: rtl/oflow_mem_pkg.sv
// optical-flow history memory, shared definitions
// word and address widths, memory depth and the history limits
// plus the region size rule used by the pointer table and the buffer
`default_nettype none

package oflow_mem_pkg;

	// --------------------------------------------------------------------
	// memory geometry
	// --------------------------------------------------------------------
	localparam int DATA_WIDTH   = 32;  // one feature word
	localparam int MEM_DEPTH    = 128; // words in the shared memory
	localparam int ADDR_WIDTH   = 7;   // log2 of depth
	localparam int OFFSET_WIDTH = 6;   // offset inside one region

	// --------------------------------------------------------------------
	// frame / history bookkeeping
	// --------------------------------------------------------------------
	localparam int FRAME_NUM_WIDTH = 8; // frame serial 0..255
	localparam int HIST_WIDTH      = 3; // history count field
	localparam int MAX_HISTORY     = 5; // regions, also pointer regs

	// words per region, floor(depth / n)
	// one extra bit since n = 1 gives the full depth
	function automatic logic [ADDR_WIDTH:0] region_size(
		input logic [HIST_WIDTH-1:0] n
	);
		logic [ADDR_WIDTH:0] size;
		case (n)
			1: size = (ADDR_WIDTH+1)'(MEM_DEPTH / 1);
			2: size = (ADDR_WIDTH+1)'(MEM_DEPTH / 2);
			3: size = (ADDR_WIDTH+1)'(MEM_DEPTH / 3);
			4: size = (ADDR_WIDTH+1)'(MEM_DEPTH / 4);
			5: size = (ADDR_WIDTH+1)'(MEM_DEPTH / 5);
			default: size = '0; // illegal count, no regions
		endcase
		return size;
	endfunction

endpackage

`default_nettype wire
